// File: hdl/div_pkg.sv
// Divide unit shared definitions
`default_nettype none

package div_pkg;

    ////////////////////////////////////////////////////////////
    // Operation encoding
    ////////////////////////////////////////////////////////////

    // Bit 0 picks the remainder and bit 1 picks unsigned
    typedef logic [1:0] div_op_t;

    // Signed quotient
    localparam div_op_t OP_DIV  = 2'b00;
    // Signed remainder
    localparam div_op_t OP_REM  = 2'b01;
    // Unsigned quotient
    localparam div_op_t OP_DIVU = 2'b10;
    // Unsigned remainder
    localparam div_op_t OP_REMU = 2'b11;

    ////////////////////////////////////////////////////////////
    // Request tag
    ////////////////////////////////////////////////////////////

    localparam int TAG_W = 4;

    // Travels with each request and comes back on the result
    typedef logic [TAG_W-1:0] div_tag_t;

    ////////////////////////////////////////////////////////////
    // Result fixup FSM
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        FIX_IDLE,
        FIX_WAIT_CORE,
        FIX_HOLD
    } div_fix_state_t;

endpackage

`default_nettype wire

// File: hdl/clz.sv
// Leading zero count tree
`timescale 1ns/1ps
`default_nettype none

module clz #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]         clz_input,
    output logic [$clog2(WIDTH)-1:0] clz,
    output logic                     is_zero
);

    localparam int LEVELS = $clog2(WIDTH);

    // Count and nonzero flag per tree node
    // Level 0 holds single bits, level LEVELS is the root
    logic [LEVELS-1:0] cnt [LEVELS+1][WIDTH];
    logic              nz  [LEVELS+1][WIDTH];

    genvar lvl;
    genvar node;
    generate
        // Leaves, MSB first
        for (node = 0; node < WIDTH; node++) begin : g_leaf
            assign nz[0][node]  = clz_input[WIDTH-1-node];
            assign cnt[0][node] = '0;
        end

        for (lvl = 0; lvl < LEVELS; lvl++) begin : g_level
            for (node = 0; node < (WIDTH >> (lvl + 1)); node++) begin : g_node
                // Left child is the upper half
                assign nz[lvl+1][node] = nz[lvl][2*node] | nz[lvl][2*node+1];
                // Empty upper half adds its full width of zeros
                assign cnt[lvl+1][node] = nz[lvl][2*node] ? cnt[lvl][2*node]
                                        : LEVELS'(2**lvl) + cnt[lvl][2*node+1];
            end
        end
    endgenerate

    // Root outputs, count reads WIDTH-1 for an all-zero input
    assign clz     = cnt[LEVELS][0];
    assign is_zero = ~nz[LEVELS][0];

endmodule

`default_nettype wire

// File: hdl/div_operand_prep.sv
// Divide operand preparation
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep #(
    parameter int WIDTH    = 32,
    parameter int IN_DEPTH = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  div_pkg::div_op_t  in_op,
    input  logic [WIDTH-1:0]  in_a,
    input  logic [WIDTH-1:0]  in_b,
    input  div_pkg::div_tag_t in_tag,
    output logic              in_credit,
    output logic              core_start,
    output logic [WIDTH-1:0]  core_a,
    output logic [WIDTH-1:0]  core_b,
    input  logic              core_ack,
    output div_pkg::div_op_t  fix_op,
    output div_pkg::div_tag_t fix_tag,
    output logic              fix_neg_q,
    output logic              fix_neg_r,
    output logic              fix_overflow,
    output logic [WIDTH-1:0]  fix_a
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);

    // Request buffer storage
    div_pkg::div_op_t  op_mem  [IN_DEPTH];
    logic [WIDTH-1:0]  a_mem   [IN_DEPTH];
    logic [WIDTH-1:0]  b_mem   [IN_DEPTH];
    div_pkg::div_tag_t tag_mem [IN_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    // One credit for the core
    logic             core_credit;

    // Head entry decode
    div_pkg::div_op_t head_op;
    logic [WIDTH-1:0] head_a;
    logic [WIDTH-1:0] head_b;
    logic             is_signed;
    logic             a_neg;
    logic             b_neg;

    // Circular pointer advance
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Buffer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_mem[wr_ptr]  <= in_op;
            a_mem[wr_ptr]   <= in_a;
            b_mem[wr_ptr]   <= in_b;
            tag_mem[wr_ptr] <= in_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            core_credit <= 1'b1;
        end else begin
            if (in_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (core_start)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(in_valid) - CNT_W'(core_start);
            // Start and ack never meet, the core is idle at start
            if (core_start)
                core_credit <= 1'b0;
            else if (core_ack)
                core_credit <= 1'b1;
        end
    end

    // Issue head as soon as the core credit is held
    assign core_start = (count != '0) && core_credit;
    // Slot frees on issue
    assign in_credit  = core_start;

    ////////////////////////////////////////////////////////////
    // Sign handling
    ////////////////////////////////////////////////////////////

    assign head_op   = op_mem[rd_ptr];
    assign head_a    = a_mem[rd_ptr];
    assign head_b    = b_mem[rd_ptr];
    assign is_signed = ~head_op[1];
    assign a_neg     = is_signed & head_a[WIDTH-1];
    assign b_neg     = is_signed & head_b[WIDTH-1];

    // Magnitudes, most negative value maps onto itself
    assign core_a = a_neg ? -head_a : head_a;
    assign core_b = b_neg ? -head_b : head_b;

    // Side information for fixup
    assign fix_op       = head_op;
    assign fix_tag      = tag_mem[rd_ptr];
    assign fix_a        = head_a;
    assign fix_neg_q    = a_neg ^ b_neg;
    // Remainder follows the dividend sign
    assign fix_neg_r    = a_neg;
    assign fix_overflow = is_signed & (head_a == {1'b1, {(WIDTH-1){1'b0}}}) & (&head_b);

endmodule

`default_nettype wire

// File: hdl/div_quick_clz.sv
// CLZ accelerated divider core
`timescale 1ns/1ps
`default_nettype none

module div_quick_clz #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             core_start,
    input  logic             core_ack,
    input  logic [WIDTH-1:0] core_a,
    input  logic [WIDTH-1:0] core_b,
    output logic [WIDTH-1:0] core_q,
    output logic [WIDTH-1:0] core_r,
    output logic             core_done,
    output logic             core_b_zero
);

    localparam int CLZ_W = $clog2(WIDTH);

    // Control
    logic first_cycle;
    logic running;
    logic terminate;

    // Latched operands
    logic [WIDTH-1:0] a_r;
    logic [WIDTH-1:0] b_r;
    logic [CLZ_W-1:0] b_clz;
    logic [CLZ_W-1:0] b_clz_r;
    logic             b_is_zero;
    logic             b_zero_r;
    // Divisor with its leading one at the MSB
    logic [WIDTH-1:0] shifted_b;

    // Iteration datapath
    logic [CLZ_W-1:0] r_clz;
    logic [CLZ_W-1:0] clz_delta;
    logic [WIDTH-1:0] b1;
    logic [WIDTH-1:0] b2;
    logic [WIDTH:0]   diff1;
    logic [WIDTH:0]   diff0;
    logic [WIDTH-1:0] diff2;
    logic [WIDTH-1:0] q_bit1;
    logic [WIDTH-1:0] q_bit2;
    logic [WIDTH-1:0] new_q_bit;
    logic [WIDTH-1:0] new_r;

    clz #(.WIDTH(WIDTH)) i_clz_r (
        .clz_input (core_r),
        .clz       (r_clz),
        .is_zero   ()
    );

    clz #(.WIDTH(WIDTH)) i_clz_b (
        .clz_input (core_b),
        .clz       (b_clz),
        .is_zero   (b_is_zero)
    );

    ////////////////////////////////////////////////////////////
    // Setup, two cycles
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (core_start) begin
            a_r      <= core_a;
            b_r      <= core_b;
            b_clz_r  <= b_clz;
            b_zero_r <= b_is_zero;
        end
        // Normalized divisor ready one cycle after the latch
        shifted_b <= b_r << b_clz_r;
    end

    assign core_b_zero = b_zero_r;

    ////////////////////////////////////////////////////////////
    // Quotient bit selection
    ////////////////////////////////////////////////////////////

    // Distance between the remainder's and the divisor's leading ones
    assign clz_delta = b_clz_r - r_clz;

    always_comb begin
        q_bit1 = '0;
        q_bit1[clz_delta] = 1'b1;
    end
    assign q_bit2 = q_bit1 >> 1;

    // Divisor aligned to the remainder, and half of it
    assign b1    = shifted_b >> r_clz;
    assign b2    = b1 >> 1;
    assign diff1 = {1'b0, core_r} - {1'b0, b1};
    assign diff2 = core_r - b2;
    assign diff0 = {1'b0, core_r} - ({1'b0, b1} + {1'b0, b2});

    always_comb begin
        if (diff1[WIDTH]) begin
            // Aligned divisor too large, half fits
            new_q_bit = q_bit2;
            new_r     = diff2;
        end else if (diff0[WIDTH] || clz_delta == '0) begin
            new_q_bit = q_bit1;
            new_r     = diff1[WIDTH-1:0];
        end else begin
            // Both fit, two bits retired
            new_q_bit = q_bit1 | q_bit2;
            new_r     = diff0[WIDTH-1:0];
        end
    end

    assign terminate = core_r < b_r;

    ////////////////////////////////////////////////////////////
    // Control and result registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            first_cycle <= 1'b0;
            running     <= 1'b0;
            core_done   <= 1'b0;
        end else begin
            first_cycle <= core_start;
            if (first_cycle & ~b_zero_r)
                running <= 1'b1;
            else if (terminate)
                running <= 1'b0;
            // Held until fixup takes it
            if (core_ack)
                core_done <= 1'b0;
            else if ((running & terminate) | (first_cycle & b_zero_r))
                core_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (first_cycle) begin
            // Zero divisor gives all ones and keeps the dividend
            core_q <= b_zero_r ? '1 : '0;
            core_r <= a_r;
        end else if (running & ~terminate) begin
            core_q <= core_q | new_q_bit;
            core_r <= new_r;
        end
    end

endmodule

`default_nettype wire

// File: hdl/div_result_fix.sv
// Divide result fixup
`timescale 1ns/1ps
`default_nettype none

module div_result_fix #(
    parameter int WIDTH = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              core_done,
    input  logic [WIDTH-1:0]  core_q,
    input  logic [WIDTH-1:0]  core_r,
    input  logic              core_b_zero,
    output logic              core_ack,
    input  div_pkg::div_op_t  fix_op,
    input  div_pkg::div_tag_t fix_tag,
    input  logic              fix_neg_q,
    input  logic              fix_neg_r,
    input  logic              fix_overflow,
    input  logic [WIDTH-1:0]  fix_a,
    input  logic              core_start,
    output logic              out_valid,
    output logic [WIDTH-1:0]  out_result,
    output div_pkg::div_tag_t out_tag,
    input  logic              out_credit
);

    // Room for eight consumer credits
    localparam int CRED_W = 4;

    div_pkg::div_fix_state_t state;
    div_pkg::div_fix_state_t state_nxt;

    // Side information of the division in the core
    div_pkg::div_op_t  side_op;
    div_pkg::div_tag_t side_tag;
    logic              side_neg_q;
    logic              side_neg_r;
    logic              side_overflow;
    logic [WIDTH-1:0]  side_a;

    logic              core_busy;
    logic [CRED_W-1:0] credit_cnt;
    logic              send;
    logic [WIDTH-1:0]  result_nxt;

    always_ff @(posedge clk) begin
        if (core_start) begin
            side_op       <= fix_op;
            side_tag      <= fix_tag;
            side_neg_q    <= fix_neg_q;
            side_neg_r    <= fix_neg_r;
            side_overflow <= fix_overflow;
            side_a        <= fix_a;
        end
    end

    ////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////

    assign send      = (state == div_pkg::FIX_HOLD) && (credit_cnt != '0);
    assign out_valid = send;
    // Take core result only when the output register is free this cycle
    assign core_ack  = core_done && ((state == div_pkg::FIX_WAIT_CORE) || send);

    always_comb begin
        state_nxt = state;
        case (state)
            div_pkg::FIX_IDLE:
                if (core_start)
                    state_nxt = div_pkg::FIX_WAIT_CORE;
            div_pkg::FIX_WAIT_CORE:
                if (core_done)
                    state_nxt = div_pkg::FIX_HOLD;
            div_pkg::FIX_HOLD:
                if (send && !core_done) begin
                    // Another division may have started meanwhile
                    if (core_busy || core_start)
                        state_nxt = div_pkg::FIX_WAIT_CORE;
                    else
                        state_nxt = div_pkg::FIX_IDLE;
                end
            default:
                state_nxt = div_pkg::FIX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= div_pkg::FIX_IDLE;
            core_busy  <= 1'b0;
            credit_cnt <= '0;
        end else begin
            state      <= state_nxt;
            if (core_start)
                core_busy <= 1'b1;
            else if (core_ack)
                core_busy <= 1'b0;
            credit_cnt <= credit_cnt + CRED_W'(out_credit) - CRED_W'(send);
        end
    end

    ////////////////////////////////////////////////////////////
    // Result selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (core_b_zero)
            result_nxt = side_op[0] ? side_a : '1;
        else if (side_overflow)
            result_nxt = side_op[0] ? '0 : side_a;
        else if (side_op[0])
            result_nxt = side_neg_r ? -core_r : core_r;
        else
            result_nxt = side_neg_q ? -core_q : core_q;
    end

    always_ff @(posedge clk) begin
        if (core_ack) begin
            out_result <= result_nxt;
            out_tag    <= side_tag;
        end
    end

endmodule

`default_nettype wire

// File: hdl/div_unit.sv
// Integer divide unit top
`timescale 1ns/1ps
`default_nettype none

module div_unit #(
    parameter int WIDTH    = 32,
    parameter int IN_DEPTH = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  div_pkg::div_op_t  in_op,
    input  logic [WIDTH-1:0]  in_a,
    input  logic [WIDTH-1:0]  in_b,
    input  div_pkg::div_tag_t in_tag,
    output logic              in_credit,
    output logic              out_valid,
    output logic [WIDTH-1:0]  out_result,
    output div_pkg::div_tag_t out_tag,
    input  logic              out_credit
);

    // Prep to core
    logic              core_start;
    logic [WIDTH-1:0]  core_a;
    logic [WIDTH-1:0]  core_b;
    // Core to fixup
    logic              core_done;
    logic              core_ack;
    logic [WIDTH-1:0]  core_q;
    logic [WIDTH-1:0]  core_r;
    logic              core_b_zero;
    // Prep to fixup
    div_pkg::div_op_t  fix_op;
    div_pkg::div_tag_t fix_tag;
    logic              fix_neg_q;
    logic              fix_neg_r;
    logic              fix_overflow;
    logic [WIDTH-1:0]  fix_a;

    div_operand_prep #(.WIDTH(WIDTH), .IN_DEPTH(IN_DEPTH)) i_prep (
        .clk, .rst,
        .in_valid, .in_op, .in_a, .in_b, .in_tag, .in_credit,
        .core_start, .core_a, .core_b, .core_ack,
        .fix_op, .fix_tag, .fix_neg_q, .fix_neg_r, .fix_overflow, .fix_a
    );

    div_quick_clz #(.WIDTH(WIDTH)) i_core (
        .clk, .rst,
        .core_start, .core_ack, .core_a, .core_b,
        .core_q, .core_r, .core_done, .core_b_zero
    );

    div_result_fix #(.WIDTH(WIDTH)) i_fix (
        .clk, .rst,
        .core_done, .core_q, .core_r, .core_b_zero, .core_ack,
        .fix_op, .fix_tag, .fix_neg_q, .fix_neg_r, .fix_overflow, .fix_a,
        .core_start,
        .out_valid, .out_result, .out_tag, .out_credit
    );

endmodule

`default_nettype wire

// File: tb/div_unit_tb.sv
// Divide unit testbench
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb;

    localparam int WIDTH    = 32;
    localparam int IN_DEPTH = 2;
    localparam int TIMEOUT  = 500;
    localparam logic [WIDTH-1:0] MIN_NEG = {1'b1, {(WIDTH-1){1'b0}}};

    logic              clk = 1'b0;
    logic              rst;
    logic              in_valid;
    div_pkg::div_op_t  in_op;
    logic [WIDTH-1:0]  in_a;
    logic [WIDTH-1:0]  in_b;
    div_pkg::div_tag_t in_tag;
    logic              in_credit;
    logic              out_valid;
    logic [WIDTH-1:0]  out_result;
    div_pkg::div_tag_t out_tag;
    logic              out_credit;

    // Expected results and tags in request order
    logic [WIDTH-1:0]  exp_res_q [$];
    div_pkg::div_tag_t exp_tag_q [$];
    div_pkg::div_tag_t next_tag = '0;

    // Producer and consumer bookkeeping
    int prod_credits = IN_DEPTH;
    int credit_pulses = 0;
    int accepted = 0;
    int results_out = 0;
    int cons_given = 0;

    // Check counters
    int    checks = 0;
    int    errors = 0;
    int    tests = 0;
    int    test_checks = 0;
    int    test_errors = 0;
    string cur_test = "reset";

    div_unit #(.WIDTH(WIDTH), .IN_DEPTH(IN_DEPTH)) i_dut (
        .clk, .rst,
        .in_valid, .in_op, .in_a, .in_b, .in_tag, .in_credit,
        .out_valid, .out_result, .out_tag, .out_credit
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // RISC-V M extension rules
    function automatic logic [WIDTH-1:0] ref_result(input div_pkg::div_op_t op,
                                                    input logic [WIDTH-1:0] a,
                                                    input logic [WIDTH-1:0] b);
        logic signed [WIDTH-1:0] sa;
        logic signed [WIDTH-1:0] sb;
        logic                    rem;
        sa  = a;
        sb  = b;
        rem = (op == div_pkg::OP_REM) || (op == div_pkg::OP_REMU);
        // Zero divisor, all ones or the dividend
        if (b == '0)
            return rem ? a : '1;
        if (op == div_pkg::OP_DIVU)
            return a / b;
        if (op == div_pkg::OP_REMU)
            return a % b;
        // Signed overflow keeps the dividend, remainder zero
        if (a == MIN_NEG && b == '1)
            return rem ? '0 : a;
        if (op == div_pkg::OP_DIV)
            return sa / sb;
        return sa % sb;
    endfunction

    ////////////////////////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////////////////////////

    task automatic check_result;
        logic [WIDTH-1:0]  exp_res;
        div_pkg::div_tag_t exp_tag;
        results_out++;
        checks++;
        assert (results_out <= cons_given) else begin
            errors++;
            $display("%s: result sent without a consumer credit", cur_test);
        end
        checks++;
        assert (exp_res_q.size() > 0) else begin
            errors++;
            $display("%s: result came out with no request outstanding", cur_test);
        end
        if (exp_res_q.size() > 0) begin
            exp_res = exp_res_q.pop_front();
            exp_tag = exp_tag_q.pop_front();
            checks++;
            assert (out_tag == exp_tag) else begin
                errors++;
                $display("ERR %s tag expected %h actual %h", cur_test, exp_tag, out_tag);
            end
            checks++;
            assert (out_result == exp_res) else begin
                errors++;
                $display("ERR %s result expected %h actual %h", cur_test, exp_res, out_result);
            end
        end
    endtask

    // Outputs come from registers, so the edge sees settled values
    always @(posedge clk) begin
        if (!rst) begin
            if (in_credit) begin
                prod_credits++;
                credit_pulses++;
                checks++;
                assert (prod_credits <= IN_DEPTH) else begin
                    errors++;
                    $display("%s: producer holds more credits than buffer slots", cur_test);
                end
            end
            if (out_valid)
                check_result();
        end
    end

    ////////////////////////////////////////////////////////////
    // Driver tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_on_timeout(input string what);
        $display("%s: timed out waiting for %s", cur_test, what);
        $display("Testbench failed");
        $finish;
    endtask

    // One request per falling edge while a producer credit is held
    task automatic send_req(input div_pkg::div_op_t op, input logic [WIDTH-1:0] a,
                            input logic [WIDTH-1:0] b);
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        while (prod_credits == 0) begin
            if (waited == TIMEOUT)
                stop_on_timeout("a producer credit");
            @(negedge clk);
            waited++;
        end
        in_valid = 1'b1;
        in_op    = op;
        in_a     = a;
        in_b     = b;
        in_tag   = next_tag;
        exp_res_q.push_back(ref_result(op, a, b));
        exp_tag_q.push_back(next_tag);
        next_tag++;
        prod_credits--;
        accepted++;
    endtask

    task automatic stop_input;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic return_credits(input int n);
        repeat (n) begin
            @(negedge clk);
            out_credit = 1'b1;
            cons_given++;
        end
        @(negedge clk);
        out_credit = 1'b0;
    endtask

    task automatic wait_results(input int target);
        int waited;
        waited = 0;
        while (results_out < target) begin
            if (waited == TIMEOUT)
                stop_on_timeout("results from the divide unit");
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic check_reset_outputs;
        checks++;
        assert (in_credit === 1'b0 && out_valid === 1'b0) else begin
            errors++;
            $display("ERR %s credit and valid expected 00 actual %b%b",
                     cur_test, in_credit, out_valid);
        end
    endtask

    task automatic test_done;
        $display("test %-12s %0d checks, %0d errors", cur_test,
                 checks - test_checks, errors - test_errors);
        tests++;
        test_checks = checks;
        test_errors = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_unsigned;
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        cur_test = "unsigned";
        repeat (4) begin
            return_credits(8);
            repeat (8) begin
                a = $urandom;
                // Shifted divisor spreads the core latency
                b = $urandom >> ($urandom % WIDTH);
                send_req(($urandom % 2) ? div_pkg::OP_DIVU : div_pkg::OP_REMU, a, b);
            end
            stop_input();
            wait_results(cons_given);
        end
        test_done();
    endtask

    task automatic test_signed;
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        cur_test = "signed";
        // Bit 0 negates the dividend, bit 1 the divisor
        for (int s = 0; s < 4; s++) begin
            return_credits(4);
            repeat (2) begin
                a = $urandom >> 1;
                b = (($urandom >> 1) >> ($urandom % (WIDTH - 1))) | 1;
                if (s[0])
                    a = -a;
                if (s[1])
                    b = -b;
                send_req(div_pkg::OP_DIV, a, b);
                send_req(div_pkg::OP_REM, a, b);
            end
            stop_input();
            wait_results(cons_given);
        end
        test_done();
    endtask

    task automatic test_special;
        logic [WIDTH-1:0] a;
        cur_test = "special";
        a = $urandom;
        return_credits(8);
        send_req(div_pkg::OP_DIV, a, '0);
        send_req(div_pkg::OP_REM, a, '0);
        send_req(div_pkg::OP_DIVU, a, '0);
        send_req(div_pkg::OP_REMU, a, '0);
        // Most negative over minus one, then the same bits unsigned
        send_req(div_pkg::OP_DIV, MIN_NEG, '1);
        send_req(div_pkg::OP_REM, MIN_NEG, '1);
        send_req(div_pkg::OP_DIVU, MIN_NEG, '1);
        send_req(div_pkg::OP_REMU, MIN_NEG, '1);
        stop_input();
        wait_results(cons_given);
        test_done();
    endtask

    task automatic test_producer;
        int start_acc;
        int start_pulses;
        cur_test = "producer";
        start_acc    = accepted;
        start_pulses = credit_pulses;
        return_credits(8);
        // Back to back, throttled only by producer credits
        repeat (8)
            send_req(div_pkg::div_op_t'($urandom % 4), $urandom, $urandom >> ($urandom % 16));
        stop_input();
        wait_results(cons_given);
        checks++;
        assert (credit_pulses - start_pulses == accepted - start_acc) else begin
            errors++;
            $display("ERR %s credit pulses expected %0d actual %0d", cur_test,
                     accepted - start_acc, credit_pulses - start_pulses);
        end
        checks++;
        assert (prod_credits == IN_DEPTH) else begin
            errors++;
            $display("ERR %s producer credits expected %0d actual %0d", cur_test,
                     IN_DEPTH, prod_credits);
        end
        test_done();
    endtask

    task automatic test_backpressure;
        int base;
        cur_test = "backpressure";
        base = results_out;
        // Fills buffer, core and output register with no consumer credit
        repeat (4)
            send_req(div_pkg::div_op_t'($urandom % 4), $urandom, $urandom >> ($urandom % 24));
        stop_input();
        repeat (40) @(negedge clk);
        checks++;
        assert (results_out == base) else begin
            errors++;
            $display("ERR %s results expected %0d actual %0d", cur_test, 0, results_out - base);
        end
        return_credits(2);
        wait_results(cons_given);
        repeat (20) @(negedge clk);
        checks++;
        assert (results_out - base == 2) else begin
            errors++;
            $display("ERR %s results expected %0d actual %0d", cur_test, 2, results_out - base);
        end
        return_credits(2);
        wait_results(cons_given);
        test_done();
    endtask

    initial begin
        void'($urandom(32'hf3f491b5));
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_op      = div_pkg::OP_DIV;
        in_a       = '0;
        in_b       = '0;
        in_tag     = '0;
        out_credit = 1'b0;
        // Two reset cycles, then the first cycle out of reset
        repeat (2) begin
            @(negedge clk);
            check_reset_outputs();
        end
        rst = 1'b0;
        @(negedge clk);
        check_reset_outputs();
        test_done();

        test_unsigned();
        test_signed();
        test_special();
        test_producer();
        test_backpressure();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hdl/div_pkg.sv
hdl/clz.sv
hdl/div_operand_prep.sv
hdl/div_quick_clz.sv
hdl/div_result_fix.sv
hdl/div_unit.sv
tb/div_unit_tb.sv

// File: Bender.yml
package:
  name: div_unit

sources:
  # Package first, then the stages, then the top level
  - files:
      - hdl/div_pkg.sv
      - hdl/clz.sv
      - hdl/div_operand_prep.sv
      - hdl/div_quick_clz.sv
      - hdl/div_result_fix.sv
      - hdl/div_unit.sv

  # Testbench, top module div_unit_tb
  - target: test
    files:
      - tb/div_unit_tb.sv
